/* source/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    // Cache geometry
    localparam int WORD_W    = 32;
    localparam int TAG_W     = 26;
    localparam int IDX_W     = 3;
    localparam int BLK_W     = 1;
    localparam int BYT_W     = 2;
    localparam int WAY_COUNT = 2;
    localparam int SET_COUNT = 8;
    localparam int BLK_WORDS = 2;
    localparam int WAY_W     = 1;

    // Widths with a meaning
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [TAG_W-1:0]  tag_t;
    typedef logic [IDX_W-1:0]  idx_t;
    typedef logic [BLK_W-1:0]  blk_t;
    typedef logic [WAY_W-1:0]  way_t;

    // Address split, tag in bits 31:6
    typedef struct packed {
        tag_t             tag;
        idx_t             idx;
        blk_t             blk;
        logic [BYT_W-1:0] byt;
    } dcache_addr_t;

    // One cache frame, 92 bits
    typedef struct packed {
        logic                   valid;
        logic                   dirty;
        tag_t                   tag;
        word_t [BLK_WORDS-1:0]  data;
    } frame_t;

    // Datapath side
    typedef struct packed {
        logic  ren;
        logic  wen;
        word_t addr;
        word_t store;
    } dp_req_t;

    typedef struct packed {
        logic  hit;
        word_t load;
    } dp_rsp_t;

    // Memory side, single word per access
    typedef struct packed {
        logic  ren;
        logic  wen;
        word_t addr;
        word_t store;
    } mem_req_t;

    // Way write commands
    typedef enum logic [2:0] {
        WR_NONE,
        WR_STORE,
        WR_FILL,
        WR_TAG,
        WR_CLEAN
    } way_op_t;

    typedef struct packed {
        way_op_t op;
        way_t    way;
        idx_t    idx;
        blk_t    blk;
        word_t   data;
        tag_t    tag;
    } way_wr_t;

endpackage

`default_nettype wire

/* source/dcache_way.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_way #(
    parameter dcache_pkg::way_t WAY_ID = '0
) (
    input  logic               CLK,
    input  logic               nRST,
    input  dcache_pkg::idx_t   lookup_idx,
    input  dcache_pkg::tag_t   lookup_tag,
    input  dcache_pkg::way_wr_t wr,
    output dcache_pkg::frame_t frame,
    output logic               hit
);

    import dcache_pkg::*;

    // Frame storage, one entry per set
    frame_t [SET_COUNT-1:0] sets;

    // Command addressed to this way
    logic wr_sel;

    assign wr_sel = (wr.way == WAY_ID);

    // Frame at the lookup index, read combinationally
    assign frame = sets[lookup_idx];

    // Valid frame with matching tag
    assign hit = frame.valid && (frame.tag == lookup_tag);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            // All frames invalid and clean
            sets <= '0;
        end else if (wr_sel) begin
            case (wr.op)
                WR_STORE: begin
                    // Store hit, word written and frame marked dirty
                    sets[wr.idx].data[wr.blk] <= wr.data;
                    sets[wr.idx].dirty        <= 1'b1;
                end
                WR_FILL: begin
                    // Fill word from memory
                    sets[wr.idx].data[wr.blk] <= wr.data;
                end
                WR_TAG: begin
                    // Last fill word lands together with the tag
                    sets[wr.idx].data[wr.blk] <= wr.data;
                    sets[wr.idx].tag          <= wr.tag;
                    sets[wr.idx].valid        <= 1'b1;
                    sets[wr.idx].dirty        <= 1'b0;
                end
                WR_CLEAN: begin
                    // Frame written back during flush
                    sets[wr.idx].dirty <= 1'b0;
                end
                default: begin
                    // WR_NONE leaves the frame alone
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/dcache_way_select.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_way_select (
    input  logic                                 CLK,
    input  logic                                 nRST,
    input  dcache_pkg::frame_t                   frames [dcache_pkg::WAY_COUNT],
    input  logic [dcache_pkg::WAY_COUNT-1:0]     hits,
    input  dcache_pkg::blk_t                     blk,
    input  logic                                 fill_done,
    output logic                                 hit,
    output dcache_pkg::way_t                     hit_way,
    output dcache_pkg::word_t                    load,
    output dcache_pkg::way_t                     lru
);

    import dcache_pkg::*;

    // Hit merge
    // Scan from the top way down so way 0 wins
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = WAY_COUNT - 1; w >= 0; w--) begin
            if (hits[w]) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    // Word at the block offset of the hitting frame
    // Zero when nothing hits
    always_comb begin
        if (hit) begin
            load = frames[hit_way].data[blk];
        end else begin
            load = '0;
        end
    end

    // Replacement bit
    // Advances once per completed fill, wraps over the ways
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            lru <= '0;
        end else if (fill_done) begin
            lru <= lru + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* source/dcache_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_ctrl (
    input  logic                   CLK,
    input  logic                   nRST,
    input  dcache_pkg::dp_req_t    dp_req,
    input  logic                   halt,
    input  logic                   hit,
    input  dcache_pkg::way_t       hit_way,
    input  dcache_pkg::way_t       lru,
    input  dcache_pkg::frame_t     frames [dcache_pkg::WAY_COUNT],
    input  logic                   mem_wait,
    input  dcache_pkg::word_t      mem_load,
    output dcache_pkg::idx_t       lookup_idx,
    output dcache_pkg::way_wr_t    wr,
    output logic                   fill_done,
    output dcache_pkg::mem_req_t   mem_req,
    output logic                   dhit,
    output logic                   flushed
);

    import dcache_pkg::*;

    typedef enum logic [3:0] {
        COMPARE,
        WRITE_BACK0,
        WRITE_BACK1,
        FILL0,
        FILL1,
        FLUSH_SCAN,
        FLUSH_WRITE0,
        FLUSH_WRITE1,
        FLUSHED
    } state_t;

    state_t state, state_n;

    // Flush walk position
    way_t flush_way, flush_way_n;
    idx_t flush_idx, flush_idx_n;

    // Flush moves on to the next frame this cycle
    logic flush_step;

    // Request address fields
    dcache_addr_t req;

    // Frames the miss and flush paths work on
    frame_t victim;
    frame_t flush_frame;

    // Word address from tag, index and word number
    function automatic word_t blk_addr(tag_t tag, idx_t idx, blk_t blk);
        dcache_addr_t a;
        a.tag = tag;
        a.idx = idx;
        a.blk = blk;
        a.byt = '0;
        return a;
    endfunction

    assign req         = dp_req.addr;
    assign victim      = frames[lru];
    assign flush_frame = frames[flush_way];

    // Flush walks its own counter, everything else looks up the request
    assign lookup_idx = (state == FLUSH_SCAN || state == FLUSH_WRITE0 ||
                         state == FLUSH_WRITE1) ? flush_idx : req.idx;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= COMPARE;
            flush_way <= '0;
            flush_idx <= '0;
        end else begin
            state     <= state_n;
            flush_way <= flush_way_n;
            flush_idx <= flush_idx_n;
        end
    end

    always_comb begin
        state_n     = state;
        flush_way_n = flush_way;
        flush_idx_n = flush_idx;
        flush_step  = 1'b0;
        dhit        = 1'b0;
        flushed     = 1'b0;
        fill_done   = 1'b0;
        mem_req     = '0;
        // No way write unless a state asks for one
        wr.op       = WR_NONE;
        wr.way      = lru;
        wr.idx      = req.idx;
        wr.blk      = req.blk;
        wr.data     = dp_req.store;
        wr.tag      = req.tag;

        case (state)
            COMPARE: begin
                if (halt) begin
                    // Halt wins over a pending request
                    state_n     = FLUSH_SCAN;
                    flush_way_n = '0;
                    flush_idx_n = '0;
                end else if (dp_req.ren || dp_req.wen) begin
                    if (hit) begin
                        // Hit answered in the request cycle
                        dhit = 1'b1;
                        if (dp_req.wen) begin
                            wr.op  = WR_STORE;
                            wr.way = hit_way;
                        end
                    end else if (victim.dirty) begin
                        state_n = WRITE_BACK0;
                    end else begin
                        state_n = FILL0;
                    end
                end
            end

            WRITE_BACK0: begin
                // Victim word 0 to its own address
                mem_req.wen   = 1'b1;
                mem_req.addr  = blk_addr(victim.tag, req.idx, 1'b0);
                mem_req.store = victim.data[0];
                if (!mem_wait) begin
                    state_n = WRITE_BACK1;
                end
            end

            WRITE_BACK1: begin
                mem_req.wen   = 1'b1;
                mem_req.addr  = blk_addr(victim.tag, req.idx, 1'b1);
                mem_req.store = victim.data[1];
                if (!mem_wait) begin
                    state_n = FILL0;
                end
            end

            FILL0: begin
                // Requested block word 0 into the victim way
                mem_req.ren  = 1'b1;
                mem_req.addr = blk_addr(req.tag, req.idx, 1'b0);
                if (!mem_wait) begin
                    wr.op   = WR_FILL;
                    wr.blk  = 1'b0;
                    wr.data = mem_load;
                    state_n = FILL1;
                end
            end

            FILL1: begin
                mem_req.ren  = 1'b1;
                mem_req.addr = blk_addr(req.tag, req.idx, 1'b1);
                if (!mem_wait) begin
                    // Word 1 with the tag makes the frame valid
                    wr.op     = WR_TAG;
                    wr.blk    = 1'b1;
                    wr.data   = mem_load;
                    fill_done = 1'b1;
                    state_n   = COMPARE;
                end
            end

            FLUSH_SCAN: begin
                // Clean frames cost one cycle each
                if (flush_frame.dirty) begin
                    state_n = FLUSH_WRITE0;
                end else begin
                    flush_step = 1'b1;
                end
            end

            FLUSH_WRITE0: begin
                mem_req.wen   = 1'b1;
                mem_req.addr  = blk_addr(flush_frame.tag, flush_idx, 1'b0);
                mem_req.store = flush_frame.data[0];
                if (!mem_wait) begin
                    state_n = FLUSH_WRITE1;
                end
            end

            FLUSH_WRITE1: begin
                mem_req.wen   = 1'b1;
                mem_req.addr  = blk_addr(flush_frame.tag, flush_idx, 1'b1);
                mem_req.store = flush_frame.data[1];
                if (!mem_wait) begin
                    // Frame now matches memory
                    wr.op      = WR_CLEAN;
                    wr.way     = flush_way;
                    wr.idx     = flush_idx;
                    flush_step = 1'b1;
                    state_n    = FLUSH_SCAN;
                end
            end

            FLUSHED: begin
                // Held until reset
                flushed = 1'b1;
            end

            default: begin
                state_n = COMPARE;
            end
        endcase

        // Next frame of the walk, all sets of one way before the next way
        if (flush_step) begin
            if (flush_idx == idx_t'(SET_COUNT - 1)) begin
                flush_idx_n = '0;
                if (flush_way == way_t'(WAY_COUNT - 1)) begin
                    state_n = FLUSHED;
                end else begin
                    flush_way_n = flush_way + 1'b1;
                end
            end else begin
                flush_idx_n = flush_idx + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/dcache.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache (
    input  logic                  CLK,
    input  logic                  nRST,
    input  dcache_pkg::dp_req_t   dp_req,
    output dcache_pkg::dp_rsp_t   dp_rsp,
    input  logic                  halt,
    output logic                  flushed,
    output dcache_pkg::mem_req_t  mem_req,
    input  logic                  mem_wait,
    input  dcache_pkg::word_t     mem_load
);

    import dcache_pkg::*;

    // Request address split for the ways and the selector
    dcache_addr_t req_addr;

    // Way fan-out and fan-in
    idx_t                 lookup_idx;
    way_wr_t              wr;
    frame_t               way_frames [WAY_COUNT];
    logic [WAY_COUNT-1:0] way_hits;

    // Selector results
    logic  sel_hit;
    way_t  sel_hit_way;
    way_t  sel_lru;
    word_t sel_load;
    logic  fill_done;
    logic  dhit;

    assign req_addr = dp_req.addr;

    // Load is zero unless the cache answers
    assign dp_rsp.hit  = dhit;
    assign dp_rsp.load = dhit ? sel_load : '0;

    // Identical ways, each picks its own commands by WAY_ID
    for (genvar g = 0; g < WAY_COUNT; g++) begin : g_way
        dcache_way #(
            .WAY_ID (way_t'(g))
        ) u_way (
            .CLK        (CLK),
            .nRST       (nRST),
            .lookup_idx (lookup_idx),
            .lookup_tag (req_addr.tag),
            .wr         (wr),
            .frame      (way_frames[g]),
            .hit        (way_hits[g])
        );
    end

    dcache_way_select u_sel (
        .CLK       (CLK),
        .nRST      (nRST),
        .frames    (way_frames),
        .hits      (way_hits),
        .blk       (req_addr.blk),
        .fill_done (fill_done),
        .hit       (sel_hit),
        .hit_way   (sel_hit_way),
        .load      (sel_load),
        .lru       (sel_lru)
    );

    dcache_ctrl u_ctrl (
        .CLK        (CLK),
        .nRST       (nRST),
        .dp_req     (dp_req),
        .halt       (halt),
        .hit        (sel_hit),
        .hit_way    (sel_hit_way),
        .lru        (sel_lru),
        .frames     (way_frames),
        .mem_wait   (mem_wait),
        .mem_load   (mem_load),
        .lookup_idx (lookup_idx),
        .wr         (wr),
        .fill_done  (fill_done),
        .mem_req    (mem_req),
        .dhit       (dhit),
        .flushed    (flushed)
    );

endmodule

`default_nettype wire

/* sim/dcache_chk.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_chk (
    input logic                 CLK,
    input logic                 nRST,
    input dcache_pkg::mem_req_t mem_req,
    input dcache_pkg::dp_rsp_t  dp_rsp,
    input logic                 flushed
);

    import dcache_pkg::*;

    // Failed assertions so far
    int unsigned fail_count = 0;

    // One memory access direction at a time
    a_one_dir: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_req.ren && mem_req.wen))
        else begin
            $error("memory read and write requested together");
            fail_count++;
        end

    // Word aligned memory addresses
    a_aligned: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_req.ren || mem_req.wen) |-> (mem_req.addr[1:0] == 2'b00))
        else begin
            $error("memory address %h has a byte offset", mem_req.addr);
            fail_count++;
        end

    // Flushed holds until reset
    a_flushed_held: assert property (@(posedge CLK) disable iff (!nRST)
        flushed |=> flushed)
        else begin
            $error("flushed dropped before reset");
            fail_count++;
        end

    // No datapath answer once flushed
    a_no_hit_flushed: assert property (@(posedge CLK) disable iff (!nRST)
        !(dp_rsp.hit && flushed))
        else begin
            $error("dhit high while flushed");
            fail_count++;
        end

endmodule

`default_nettype wire

/* sim/dcache_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_tb;

    import dcache_pkg::*;

    localparam int    ACCESS_TIMEOUT = 40;
    localparam int    FLUSH_TIMEOUT  = 300;
    localparam word_t FILL_PATTERN   = 32'hA5C3_0F96;

    logic     CLK = 1'b0;
    logic     nRST;
    dp_req_t  dp_req;
    dp_rsp_t  dp_rsp;
    logic     halt;
    logic     flushed;
    mem_req_t mem_req;
    logic     mem_wait;
    word_t    mem_load;

    // Memory model, 64 words, and the expected image of memory
    word_t  mem [64];
    word_t  ref_mem [64];
    word_t  wr_addr_log [$];
    word_t  wr_data_log [$];
    int     wait_left;
    integer seed = 94;

    string test_name;
    int    test_errors;
    int    total_errors;
    int    tests_run;
    int    tests_failed;

    dcache DUT (
        .CLK      (CLK),
        .nRST     (nRST),
        .dp_req   (dp_req),
        .dp_rsp   (dp_rsp),
        .halt     (halt),
        .flushed  (flushed),
        .mem_req  (mem_req),
        .mem_wait (mem_wait),
        .mem_load (mem_load)
    );

    bind dcache dcache_chk u_chk (
        .CLK     (CLK),
        .nRST    (nRST),
        .mem_req (mem_req),
        .dp_rsp  (dp_rsp),
        .flushed (flushed)
    );

    always #10 CLK = ~CLK;

    // Read data follows the request address
    assign mem_load = mem[mem_req.addr[7:2]];

    // Initial memory word, address xor a fixed pattern
    function automatic word_t fill_word(int i);
        return word_t'(i << 2) ^ FILL_PATTERN;
    endfunction

    // Memory model with 0 to 3 random wait cycles per access
    initial begin
        bit active;
        mem_wait  = 1'b0;
        wait_left = 0;
        for (int i = 0; i < 64; i++) begin
            mem[i] = fill_word(i);
        end
        forever begin
            @(negedge CLK);
            active = nRST && (mem_req.ren || mem_req.wen);
            if (active && !mem_wait) begin
                // Access completes at the coming edge
                if (mem_req.wen) begin
                    mem[mem_req.addr[7:2]] = mem_req.store;
                    wr_addr_log.push_back(mem_req.addr);
                    wr_data_log.push_back(mem_req.store);
                end
                wait_left = $random(seed) & 3;
            end else if (active && wait_left != 0) begin
                wait_left--;
            end
            @(posedge CLK);
            #2;
            mem_wait = nRST && (wait_left != 0);
        end
    end

    task automatic check_value(input string what, input word_t exp, input word_t act);
        assert (act === exp) else begin
            $display("** Error %s: %s expected %h actual %h", test_name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic finish_test();
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("test %s passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", test_name, test_errors);
        end
    endtask

    // One datapath request held until dhit, entered 2 ns after an edge
    task automatic dp_access(input logic is_write, input word_t addr, input word_t data,
                             output word_t load, output int wait_cycles);
        bit done;
        done        = 1'b0;
        wait_cycles = 0;
        load        = '0;
        dp_req.ren   = !is_write;
        dp_req.wen   = is_write;
        dp_req.addr  = addr;
        dp_req.store = data;
        while (!done && wait_cycles < ACCESS_TIMEOUT) begin
            @(negedge CLK);
            if (dp_rsp.hit) begin
                done = 1'b1;
                load = dp_rsp.load;
            end else begin
                wait_cycles++;
            end
            @(posedge CLK);
            #2;
        end
        dp_req = '0;
        assert (done) else begin
            $display("%s: no dhit for address %h within %0d cycles",
                     test_name, addr, ACCESS_TIMEOUT);
            test_errors++;
        end
        if (done && is_write) begin
            ref_mem[addr[7:2]] = data;
        end
    endtask

    task automatic read_check(input word_t addr, output int wait_cycles);
        word_t load;
        dp_access(1'b0, addr, '0, load, wait_cycles);
        check_value($sformatf("load from %h", addr), ref_mem[addr[7:2]], load);
    endtask

    task automatic store_word(input word_t addr, input word_t data, output int wait_cycles);
        word_t load;
        dp_access(1'b1, addr, data, load, wait_cycles);
    endtask

    task automatic apply_reset();
        nRST   = 1'b0;
        halt   = 1'b0;
        dp_req = '0;
        repeat (2) @(posedge CLK);
        #2;
        nRST = 1'b1;
    endtask

    task automatic test_read_miss_hit();
        int w;
        test_name   = "read_miss_hit";
        test_errors = 0;
        read_check(32'h48, w);
        // Two fills and the return to compare at least
        assert (w >= 3) else begin
            $display("%s: miss answered after only %0d cycles", test_name, w);
            test_errors++;
        end
        // Other word of the same block
        read_check(32'h4C, w);
        check_value("hit latency", '0, word_t'(w));
        finish_test();
    endtask

    task automatic test_store_hit();
        int w;
        int n;
        test_name   = "store_hit";
        test_errors = 0;
        n = wr_addr_log.size();
        store_word(32'h4C, 32'hDEAD_BEEF, w);
        check_value("store hit latency", '0, word_t'(w));
        check_value("memory writes", word_t'(n), word_t'(wr_addr_log.size()));
        read_check(32'h4C, w);
        check_value("hit latency", '0, word_t'(w));
        finish_test();
    endtask

    task automatic test_dirty_eviction();
        int w;
        int n;
        test_name   = "dirty_eviction";
        test_errors = 0;
        // Set 2, tags 0, 1, 2 in turn
        store_word(32'h10, 32'h0BAD_CAFE, w);
        read_check(32'h50, w);
        n = wr_addr_log.size();
        read_check(32'h90, w);
        check_value("write-back count", word_t'(n + 2), word_t'(wr_addr_log.size()));
        if (wr_addr_log.size() >= n + 2) begin
            check_value("write-back address 0", 32'h10, wr_addr_log[n]);
            check_value("write-back data 0", ref_mem[4], wr_data_log[n]);
            check_value("write-back address 1", 32'h14, wr_addr_log[n + 1]);
            check_value("write-back data 1", ref_mem[5], wr_data_log[n + 1]);
        end
        check_value("memory word 4", ref_mem[4], mem[4]);
        read_check(32'h10, w);
        finish_test();
    endtask

    task automatic test_flush();
        int    w;
        int    n;
        int    cycles;
        word_t a0;
        word_t wb_base [6];
        test_name   = "flush";
        test_errors = 0;
        // Set 2 dirty in both ways, a few more sets in either
        store_word(32'h90, 32'h1111_2222, w);
        store_word(32'h14, 32'h3333_4444, w);
        store_word(32'hF8, 32'h5555_6666, w);
        store_word(32'h20, 32'h7777_8888, w);
        store_word(32'h6C, 32'h9999_AAAA, w);
        // Dirty blocks by way and set, placed by the toggling replacement bit
        // Way 0 holds sets 1, 2, 4 and way 1 holds sets 2, 5, 7
        wb_base = '{32'h48, 32'h10, 32'h20, 32'h90, 32'h68, 32'hF8};
        n      = wr_addr_log.size();
        cycles = 0;
        halt   = 1'b1;
        while (!flushed && cycles < FLUSH_TIMEOUT) begin
            @(negedge CLK);
            if (!flushed) begin
                cycles++;
            end
        end
        assert (flushed) else begin
            $display("%s: flushed not raised within %0d cycles", test_name, FLUSH_TIMEOUT);
            test_errors++;
        end
        for (int i = 0; i < 64; i++) begin
            check_value($sformatf("memory word %0d", i), ref_mem[i], mem[i]);
        end
        // Word 0 then word 1 of each frame, way 0 frames first
        check_value("flush write count", 32'd12, word_t'(wr_addr_log.size() - n));
        for (int k = 0; k < 12 && n + k < wr_addr_log.size(); k++) begin
            a0 = wb_base[k / 2] | word_t'((k % 2) << 2);
            check_value($sformatf("flush write address %0d", k), a0, wr_addr_log[n + k]);
            check_value($sformatf("flush write data %0d", k), ref_mem[a0[7:2]],
                        wr_data_log[n + k]);
        end
        // Observation window after flush
        repeat (5) begin
            @(negedge CLK);
            check_value("flushed held", 32'd1, word_t'(flushed));
        end
        @(posedge CLK);
        #2;
        finish_test();
    endtask

    task automatic test_random_mix();
        int    w;
        word_t rnd;
        word_t addr;
        word_t data;
        test_name   = "random_mix";
        test_errors = 0;
        for (int i = 0; i < 60; i++) begin
            rnd  = $random(seed);
            addr = {24'h0, rnd[5:0], 2'b00};
            rnd  = $random(seed);
            data = $random(seed);
            if (rnd[0]) begin
                store_word(addr, data, w);
            end else begin
                read_check(addr, w);
            end
        end
        finish_test();
    endtask

    initial begin
        tests_run    = 0;
        tests_failed = 0;
        total_errors = 0;
        test_name    = "reset";
        for (int i = 0; i < 64; i++) begin
            ref_mem[i] = fill_word(i);
        end
        apply_reset();
        test_read_miss_hit();
        test_store_hit();
        test_dirty_eviction();
        test_flush();
        // Flushed only clears on reset, memory already matches
        apply_reset();
        test_random_mix();
        total_errors += int'(DUT.u_chk.fail_count);
        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dcache.f */
source/dcache_pkg.sv
source/dcache_way.sv
source/dcache_way_select.sv
source/dcache_ctrl.sv
source/dcache.sv
sim/dcache_chk.sv
sim/dcache_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the dcache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module dcache_tb \
    -f dcache.f -Mdir obj_dir -o dcache_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/dcache_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^RESULT: PASS$" sim.log; then
    exit 0
fi
exit 1
